/* common/fetch_consts.svh */
/*
 * Fetch front-end constants
 * Address and instruction widths, cache line geometry,
 * boot address and fetch queue depth
 */

`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// Datapath widths
`define FETCH_XLEN 32
`define FETCH_ILEN 32

// Cache line geometry, four words per line
`define FETCH_LINE_WORDS 4
`define FETCH_WORD_OFS 2
`define FETCH_LINE_OFS 2

// Reset PC
`define FETCH_BOOT_PC 32'h0000_1000

// Entries between fetch and decode, power of two
`define FETCH_QUEUE_DEPTH 4

`endif

/* common/fetch_pkg.sv */
/*
 * Fetch front-end types
 * Address and instruction vectors, cache line and queue entry
 * structs, fetch controller states
 */

`include "fetch_consts.svh"

package fetch_pkg;

  // Plain vectors
  typedef logic [`FETCH_XLEN-1:0] xlen_t;
  typedef logic [`FETCH_ILEN-1:0] inst_t;
  // Word 0 of the line sits in the low bits
  typedef logic [`FETCH_LINE_WORDS*`FETCH_ILEN-1:0] line_data_t;

  // Line returned by the instruction cache
  typedef struct packed {
    xlen_t      pc;
    line_data_t data;
  } icache_out_t;

  // PC/instruction pair handed to decode
  typedef struct packed {
    xlen_t pc;
    inst_t instr;
  } fetch_entry_t;

  // Line request controller
  typedef enum logic [1:0] {FS_IDLE, FS_WAIT, FS_DROP} fetch_state_t;

endpackage

/* verilog/pc_gen.sv */
/*
 * PC generator
 * Holds the fetch PC, steps one word per fetch and
 * takes the redirect target on a flush
 */

`timescale 1ns/10ps
`include "fetch_consts.svh"

module pc_gen (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             flush_i,
  input  fetch_pkg::xlen_t flush_pc_i,
  input  logic             fetch_ready_i,
  output fetch_pkg::xlen_t pc_o
);

  // One instruction in bytes
  localparam fetch_pkg::xlen_t PC_STEP = fetch_pkg::xlen_t'(`FETCH_ILEN / 8);

  fetch_pkg::xlen_t pc_q;
  fetch_pkg::xlen_t pc_d;

  // ------------------------------
  // Next PC
  // ------------------------------
  always_comb begin
    pc_d = pc_q;
    // Redirect wins over a same-cycle fetch
    if (flush_i) begin
      pc_d = flush_pc_i;
    end else if (fetch_ready_i) begin
      pc_d = pc_q + PC_STEP;
    end
  end

  // PC register, boot address out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pc_q <= `FETCH_BOOT_PC;
    end else begin
      pc_q <= pc_d;
    end
  end

  assign pc_o = pc_q;

endmodule

/* ifu/fetch_controller.sv */
/*
 * Fetch controller
 * Issues line requests on a miss, discards a response that
 * was overtaken by a flush, and strobes line capture and push
 */

`timescale 1ns/10ps

module fetch_controller (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic flush_i,
  input  logic hit_i,
  input  logic read_done_i,
  input  logic queue_ready_i,
  output logic read_req_o,
  output logic accept_o,
  output logic issue_o
);

  fetch_pkg::fetch_state_t state_q;
  fetch_pkg::fetch_state_t state_d;
  logic                    armed_q;

  // Keeps the request low through reset and the first cycle after
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      armed_q <= 1'b0;
    end else begin
      armed_q <= 1'b1;
    end
  end

  // ------------------------------
  // Next state and outputs
  // ------------------------------
  always_comb begin
    state_d    = state_q;
    read_req_o = 1'b0;
    accept_o   = 1'b0;
    unique case (state_q)
      fetch_pkg::FS_IDLE: begin
        // Miss seen, request at once unless redirected
        read_req_o = armed_q & ~hit_i & ~flush_i;
        if (read_req_o) begin
          state_d = fetch_pkg::FS_WAIT;
        end
      end
      fetch_pkg::FS_WAIT: begin
        read_req_o = 1'b1;
        // Line is stale when the flush comes with it
        accept_o   = read_done_i & ~flush_i;
        if (read_done_i) begin
          state_d = fetch_pkg::FS_IDLE;
        end else if (flush_i) begin
          state_d = fetch_pkg::FS_DROP;
        end
      end
      fetch_pkg::FS_DROP: begin
        // Old request held until its done, then discarded
        read_req_o = 1'b1;
        if (read_done_i) begin
          state_d = fetch_pkg::FS_IDLE;
        end
      end
      default: begin
        state_d = fetch_pkg::FS_IDLE;
      end
    endcase
  end

  // Push on a hit or a fresh line, if the queue has room
  assign issue_o = (hit_i | accept_o) & queue_ready_i & ~flush_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= fetch_pkg::FS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

/* ifu/ifu.sv */
/*
 * Instruction fetch unit
 * Holds the last cache line, checks whether the PC lies in it,
 * requests a new line on a miss and pushes the selected
 * instruction into the fetch queue
 */

`timescale 1ns/10ps
`include "fetch_consts.svh"

module ifu (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  // PC generator side
  input  fetch_pkg::xlen_t       pc_i,
  output logic                   fetch_ready_o,
  // Instruction cache side
  input  fetch_pkg::icache_out_t cache_out_i,
  input  logic                   read_done_i,
  output logic                   read_req_o,
  output fetch_pkg::xlen_t       read_addr_o,
  // Fetch queue side
  input  logic                   queue_ready_i,
  output logic                   push_o,
  output fetch_pkg::fetch_entry_t push_entry_o
);

  // Lowest address bit of the line base
  localparam int unsigned LINE_LSB = `FETCH_WORD_OFS + `FETCH_LINE_OFS;

  fetch_pkg::icache_out_t line_q;
  logic                   line_valid_q;
  fetch_pkg::xlen_t       prev_pc_q;
  fetch_pkg::xlen_t       addr_src;
  fetch_pkg::line_data_t  sel_line;
  logic [`FETCH_LINE_OFS-1:0] word_idx;
  logic                   req_q;
  logic                   hit;
  logic                   accept;
  logic                   issue;

  // ------------------------------
  // Line register
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      line_valid_q <= 1'b0;
    end else if (flush_i) begin
      line_valid_q <= 1'b0;
    end else if (accept) begin
      line_valid_q <= 1'b1;
    end
  end

  // Payload only, qualified by line_valid_q
  always_ff @(posedge clk_i) begin
    if (accept) begin
      line_q <= cache_out_i;
    end
  end

  // ------------------------------
  // Previous PC and request address
  // ------------------------------
  // Request still open after this edge
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_q <= 1'b0;
    end else begin
      req_q <= read_req_o & ~read_done_i;
    end
  end

  // Frozen while a request is open, so a flush cannot move the address
  always_ff @(posedge clk_i) begin
    if (!req_q) begin
      prev_pc_q <= pc_i;
    end
  end

  assign addr_src    = req_q ? prev_pc_q : pc_i;
  assign read_addr_o = {addr_src[`FETCH_XLEN-1:LINE_LSB], {LINE_LSB{1'b0}}};

  // Presence check on the line base bits
  assign hit = line_valid_q &
               (pc_i[`FETCH_XLEN-1:LINE_LSB] == line_q.pc[`FETCH_XLEN-1:LINE_LSB]);

  // ------------------------------
  // Fetch controller
  // ------------------------------
  fetch_controller u_fetch_controller (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .hit_i         (hit),
    .read_done_i   (read_done_i),
    .queue_ready_i (queue_ready_i),
    .read_req_o    (read_req_o),
    .accept_o      (accept),
    .issue_o       (issue)
  );

  // Instruction select
  // Bypass the fresh line on the accept cycle
  assign sel_line = accept ? cache_out_i.data : line_q.data;
  assign word_idx = pc_i[LINE_LSB-1:`FETCH_WORD_OFS];

  assign push_o             = issue;
  assign push_entry_o.pc    = pc_i;
  assign push_entry_o.instr = sel_line[word_idx*`FETCH_ILEN +: `FETCH_ILEN];

  // PC advances exactly on a push
  assign fetch_ready_o = issue;

endmodule

/* verilog/fetch_queue.sv */
/*
 * Fetch queue
 * Circular FIFO of PC/instruction pairs toward decode,
 * first word falls through from storage, flush empties it
 */

`timescale 1ns/10ps
`include "fetch_consts.svh"

module fetch_queue (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  input  logic                    push_i,
  input  fetch_pkg::fetch_entry_t push_entry_i,
  output logic                    ready_o,
  output logic                    valid_o,
  output fetch_pkg::fetch_entry_t entry_o,
  input  logic                    pop_ready_i
);

  localparam int unsigned DEPTH = `FETCH_QUEUE_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  fetch_pkg::fetch_entry_t mem_q [DEPTH];
  logic [PTR_W-1:0]        wr_ptr_q;
  logic [PTR_W-1:0]        rd_ptr_q;
  logic [CNT_W-1:0]        count_q;
  logic                    do_push;
  logic                    do_pop;

  // Handshakes
  assign ready_o = (count_q != CNT_W'(DEPTH));
  assign valid_o = (count_q != '0);
  assign do_push = push_i & ready_o;
  assign do_pop  = valid_o & pop_ready_i;
  assign entry_o = mem_q[rd_ptr_q];

  // Pointers wrap on their own with a power-of-two depth
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!do_push && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_entry_i;
    end
  end

endmodule

/* verilog/fetch_top.sv */
/*
 * Fetch front end top level
 * PC generator, fetch unit and fetch queue in a chain
 */

`timescale 1ns/10ps

module fetch_top (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // Redirect
  input  logic                    flush_i,
  input  fetch_pkg::xlen_t        flush_pc_i,
  // Instruction cache
  output logic                    read_req_o,
  output fetch_pkg::xlen_t        read_addr_o,
  input  fetch_pkg::icache_out_t  cache_out_i,
  input  logic                    read_done_i,
  // Decode
  output logic                    dec_valid_o,
  output fetch_pkg::fetch_entry_t dec_entry_o,
  input  logic                    dec_ready_i
);

  fetch_pkg::xlen_t        pc;
  logic                    fetch_ready;
  logic                    push;
  fetch_pkg::fetch_entry_t push_entry;
  logic                    queue_ready;

  // ------------------------------
  // PC generator
  // ------------------------------
  pc_gen u_pc_gen (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .flush_pc_i    (flush_pc_i),
    .fetch_ready_i (fetch_ready),
    .pc_o          (pc)
  );

  // Fetch unit
  ifu u_ifu (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .flush_i       (flush_i),
    .pc_i          (pc),
    .fetch_ready_o (fetch_ready),
    .cache_out_i   (cache_out_i),
    .read_done_i   (read_done_i),
    .read_req_o    (read_req_o),
    .read_addr_o   (read_addr_o),
    .queue_ready_i (queue_ready),
    .push_o        (push),
    .push_entry_o  (push_entry)
  );

  // Queue toward decode
  fetch_queue u_fetch_queue (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .push_i       (push),
    .push_entry_i (push_entry),
    .ready_o      (queue_ready),
    .valid_o      (dec_valid_o),
    .entry_o      (dec_entry_o),
    .pop_ready_i  (dec_ready_i)
  );

endmodule

/* dv/fetch_clk_gen.sv */
/*
 * Testbench clock and reset
 * Free-running clock, active-low reset held for a set number of cycles
 */

`timescale 1ns/10ps

module fetch_clk_gen #(
  parameter int unsigned PERIOD_NS  = 20,
  parameter int unsigned RST_CYCLES = 4
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk_o = ~clk_o;
    end
  end

  // Short high phase first, so every async reset sees a falling edge
  initial begin
    rst_n_o = 1'b1;
    #1;
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

/* dv/fetch_checker.sv */
/*
 * Fetch stream checker
 * Reference model of the PC stream and the memory image, compares
 * every entry taken by decode, watches stall stability and
 * line requests per sequential run
 */

`timescale 1ns/10ps
`include "fetch_consts.svh"

module fetch_checker (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  input  fetch_pkg::xlen_t        flush_pc_i,
  input  logic                    read_req_i,
  input  fetch_pkg::xlen_t        read_addr_i,
  input  logic                    read_done_i,
  input  logic                    dec_valid_i,
  input  fetch_pkg::fetch_entry_t dec_entry_i,
  input  logic                    dec_ready_i,
  output int unsigned             accepted_o,
  output int unsigned             value_err_o,
  output int unsigned             req_err_o,
  output int unsigned             hold_err_o
);

  fetch_pkg::xlen_t        exp_pc;
  fetch_pkg::inst_t        exp_instr;
  fetch_pkg::fetch_entry_t held_entry;
  fetch_pkg::xlen_t        seen_lines [$];
  logic                    held;
  logic                    req_open;
  logic                    dup;

  // Memory image, one word per address
  function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::xlen_t addr);
    return addr ^ 32'h5a5a_0000;
  endfunction

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      exp_pc      = `FETCH_BOOT_PC;
      held        = 1'b0;
      req_open    = 1'b0;
      value_err_o = 0;
      req_err_o   = 0;
      hold_err_o  = 0;
      accepted_o <= 0;
      seen_lines.delete();
    end else begin
      // ------------------------------
      // Stall stability
      // ------------------------------
      if (held && !dec_valid_i) begin
        $display("Decode entry withdrawn before acceptance at %0t", $time);
        hold_err_o++;
      end else if (held && (dec_entry_i !== held_entry)) begin
        $display("[ERROR] dec_entry_o: got %h, expected %h", dec_entry_i, held_entry);
        hold_err_o++;
      end
      // A flush may legally empty the queue
      held       = dec_valid_i && !dec_ready_i && !flush_i;
      held_entry = dec_entry_i;

      // Entry compare against the model
      if (dec_valid_i && dec_ready_i) begin
        exp_instr = mem_word(exp_pc);
        if (dec_entry_i.pc !== exp_pc) begin
          $display("[ERROR] dec_entry_o.pc: got %h, expected %h", dec_entry_i.pc, exp_pc);
          value_err_o++;
        end
        if (dec_entry_i.instr !== exp_instr) begin
          $display("[ERROR] dec_entry_o.instr: got %h, expected %h",
                   dec_entry_i.instr, exp_instr);
          value_err_o++;
        end
        exp_pc      = exp_pc + 32'd4;
        accepted_o <= accepted_o + 1;
      end

      // ------------------------------
      // One request per line and run
      // ------------------------------
      if (read_req_i && !req_open) begin
        dup = 1'b0;
        foreach (seen_lines[k]) begin
          if (seen_lines[k] == read_addr_i) begin
            dup = 1'b1;
          end
        end
        if (dup) begin
          $display("Line %h requested again without a flush at %0t", read_addr_i, $time);
          req_err_o++;
        end
        seen_lines.push_back(read_addr_i);
      end
      req_open = read_req_i && !read_done_i;

      // Redirect starts a new run
      if (flush_i) begin
        exp_pc = flush_pc_i;
        seen_lines.delete();
      end
    end
  end

endmodule

/* dv/fetch_sva.sv */
/*
 * Fetch front-end assertions
 * Cache and decode handshake stability, quiet outputs in reset
 */

`timescale 1ns/10ps

module fetch_sva (
  input logic                    clk_i,
  input logic                    rst_n_i,
  input logic                    flush_i,
  input logic                    read_req_i,
  input fetch_pkg::xlen_t        read_addr_i,
  input logic                    read_done_i,
  input logic                    dec_valid_i,
  input fetch_pkg::fetch_entry_t dec_entry_i,
  input logic                    dec_ready_i,
  input logic                    push_i
);

  // Failed assertions so far
  int unsigned fail_cnt = 0;

  // Open request keeps its address until done
  a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    read_req_i && !read_done_i |=> read_req_i && $stable(read_addr_i))
    else begin
      $error("read request dropped or moved before done");
      fail_cnt++;
    end

  // Offered entry held until decode takes it
  a_dec_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    dec_valid_i && !dec_ready_i && !flush_i |=> dec_valid_i && $stable(dec_entry_i))
    else begin
      $error("decode entry changed while stalled");
      fail_cnt++;
    end

  // Nothing moves in reset
  a_reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |-> !read_req_i && !dec_valid_i && !push_i)
    else begin
      $error("activity during reset");
      fail_cnt++;
    end

endmodule

bind fetch_top fetch_sva u_fetch_sva (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .flush_i     (flush_i),
  .read_req_i  (read_req_o),
  .read_addr_i (read_addr_o),
  .read_done_i (read_done_i),
  .dec_valid_i (dec_valid_o),
  .dec_entry_i (dec_entry_o),
  .dec_ready_i (dec_ready_i),
  .push_i      (push)
);

/* dv/fetch_tb.sv */
/*
 * Fetch front-end testbench
 * Scenario table of sequential runs, redirects and decode stalls,
 * instruction cache responder with random latency
 */

`timescale 1ns/10ps
`include "fetch_consts.svh"

module fetch_tb;

  localparam int unsigned NUM_ROWS  = 8;
  localparam int unsigned MAX_LAT   = 4;
  localparam logic [31:0] LFSR_SEED = 32'hc716_4aec;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // Flush goes out once count more entries are consumed
  typedef struct packed {
    logic [15:0]      count;
    logic             do_flush;
    fetch_pkg::xlen_t target;
    logic             stall;
    logic             pend;
  } scen_row_t;

  logic                    clk;
  logic                    rst_n;
  logic                    flush = 1'b0;
  fetch_pkg::xlen_t        flush_pc = '0;
  logic                    read_req;
  fetch_pkg::xlen_t        read_addr;
  fetch_pkg::icache_out_t  cache_out = '0;
  logic                    read_done = 1'b0;
  logic                    dec_valid;
  fetch_pkg::fetch_entry_t dec_entry;
  logic                    dec_ready = 1'b0;

  scen_row_t        rows [NUM_ROWS];
  logic [31:0]      lfsr_q = LFSR_SEED;
  logic             cache_busy = 1'b0;
  fetch_pkg::xlen_t req_addr = '0;
  int unsigned      wait_cnt = 0;
  int unsigned      lat;
  logic             stall_en = 1'b0;
  int unsigned      accepted;
  int unsigned      value_errs;
  int unsigned      req_errs;
  int unsigned      hold_errs;
  int unsigned      cycle_cnt = 0;
  int unsigned      timeout_cycles = 0;

  fetch_clk_gen #(.PERIOD_NS(20), .RST_CYCLES(4)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  fetch_top dut (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .flush_i     (flush),
    .flush_pc_i  (flush_pc),
    .read_req_o  (read_req),
    .read_addr_o (read_addr),
    .cache_out_i (cache_out),
    .read_done_i (read_done),
    .dec_valid_o (dec_valid),
    .dec_entry_o (dec_entry),
    .dec_ready_i (dec_ready)
  );

  fetch_checker chk (
    .clk_i (clk), .rst_n_i (rst_n), .flush_i (flush), .flush_pc_i (flush_pc),
    .read_req_i (read_req), .read_addr_i (read_addr), .read_done_i (read_done),
    .dec_valid_i (dec_valid), .dec_entry_i (dec_entry), .dec_ready_i (dec_ready),
    .accepted_o (accepted), .value_err_o (value_errs), .req_err_o (req_errs),
    .hold_err_o (hold_errs)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit
  function automatic logic [3:0] take_bits(input int unsigned n);
    logic [3:0]  v;
    int unsigned k;
    v = '0;
    for (k = 0; k < n; k++) begin
      v      = {v[2:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  // Four-word line from the checker's memory image
  function automatic fetch_pkg::icache_out_t build_line(input fetch_pkg::xlen_t base);
    fetch_pkg::icache_out_t l;
    int unsigned            w;
    l.pc = base;
    for (w = 0; w < `FETCH_LINE_WORDS; w++) begin
      l.data[w*`FETCH_ILEN +: `FETCH_ILEN] = chk.mem_word(base + 4 * w);
    end
    return l;
  endfunction

  task automatic set_row(input int unsigned idx, input int unsigned count,
                         input logic do_flush, input fetch_pkg::xlen_t target,
                         input logic stall, input logic pend);
    rows[idx].count    = count[15:0];
    rows[idx].do_flush = do_flush;
    rows[idx].target   = target;
    rows[idx].stall    = stall;
    rows[idx].pend     = pend;
  endtask

  task automatic finish_run(input logic timed_out);
    int unsigned sva_errs;
    sva_errs = dut.u_fetch_sva.fail_cnt;
    $display("Closing: %0d entries, errors value %0d, request %0d, hold %0d, assertion %0d",
             accepted, value_errs, req_errs, hold_errs, sva_errs);
    if (!timed_out && value_errs == 0 && req_errs == 0 && hold_errs == 0 &&
        sva_errs == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  endtask

  // ------------------------------
  // Cache responder and decode stalls
  // ------------------------------
  // Single block, so the LFSR bit order is fixed
  always @(posedge clk) begin
    if (!rst_n) begin
      read_done  <= 1'b0;
      cache_busy <= 1'b0;
      dec_ready  <= 1'b0;
    end else begin
      read_done <= 1'b0;
      if (stall_en) begin
        dec_ready <= (take_bits(1) != 4'd0);
      end else begin
        dec_ready <= 1'b1;
      end
      // A done cycle still shows the request just served
      if (!cache_busy && read_req && !read_done) begin
        lat = 1 + take_bits(2);
        if (lat == 1) begin
          read_done <= 1'b1;
          cache_out <= build_line(read_addr);
        end else begin
          cache_busy <= 1'b1;
          req_addr   <= read_addr;
          wait_cnt   <= lat - 1;
        end
      end else if (cache_busy) begin
        if (wait_cnt == 1) begin
          read_done  <= 1'b1;
          cache_out  <= build_line(req_addr);
          cache_busy <= 1'b0;
        end else begin
          wait_cnt <= wait_cnt - 1;
        end
      end
    end
  end

  // Timeout
  always @(negedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (timeout_cycles != 0 && cycle_cnt >= timeout_cycles) begin
      $display("Timeout after %0d cycles, decode took only %0d entries", cycle_cnt, accepted);
      finish_run(1'b1);
    end
  end

  // ------------------------------
  // Scenario table
  // ------------------------------
  initial begin
    int unsigned i;
    int unsigned total;
    int unsigned goal;
    // Row, count, flush, target, stall, flush with request open
    set_row(0, 12, 1'b0, 32'h0000_0000, 1'b0, 1'b0);
    set_row(1, 16, 1'b0, 32'h0000_0000, 1'b1, 1'b0);
    set_row(2,  6, 1'b1, 32'h0000_2000, 1'b0, 1'b0);
    set_row(3,  2, 1'b1, 32'h0000_2008, 1'b0, 1'b0);
    set_row(4,  5, 1'b1, 32'h0000_3104, 1'b0, 1'b1);
    set_row(5,  9, 1'b1, 32'h0000_4ffc, 1'b1, 1'b1);
    set_row(6,  3, 1'b1, 32'h0000_5008, 1'b0, 1'b0);
    set_row(7, 24, 1'b0, 32'h0000_0000, 1'b1, 1'b0);
    total = 0;
    for (i = 0; i < NUM_ROWS; i++) begin
      total += rows[i].count;
    end
    timeout_cycles = total * (2 * MAX_LAT + 2) + 300;

    @(posedge rst_n);
    @(posedge clk);
    goal = 0;
    for (i = 0; i < NUM_ROWS; i++) begin
      goal += rows[i].count;
      stall_en <= rows[i].stall;
      while (accepted < goal) begin
        @(posedge clk);
      end
      if (rows[i].do_flush) begin
        // Wait for a response at least two cycles away
        if (rows[i].pend) begin
          while (!(cache_busy && wait_cnt > 1)) begin
            @(posedge clk);
          end
        end
        flush    <= 1'b1;
        flush_pc <= rows[i].target;
        @(posedge clk);
        flush <= 1'b0;
      end
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    finish_run(1'b0);
  end

endmodule

/* sources.f */
+incdir+common
common/fetch_pkg.sv
verilog/pc_gen.sv
ifu/fetch_controller.sv
ifu/ifu.sv
verilog/fetch_queue.sv
verilog/fetch_top.sv
dv/fetch_clk_gen.sv
dv/fetch_checker.sv
dv/fetch_sva.sv
dv/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_front_end

export_include_dirs:
  - common

sources:
  - files:
      - common/fetch_pkg.sv
      - verilog/pc_gen.sv
      - ifu/fetch_controller.sv
      - ifu/ifu.sv
      - verilog/fetch_queue.sv
      - verilog/fetch_top.sv
  - target: test
    files:
      - dv/fetch_clk_gen.sv
      - dv/fetch_checker.sv
      - dv/fetch_sva.sv
      - dv/fetch_tb.sv
